//--- hw/gba_io_pkg.sv
// gba i/o shared definitions
// bus request/response structs, register map offsets and the
// timer, keypad and interrupt field layouts

package gba_io_pkg;

    ////////////////////
    // bus

    typedef struct packed {
        logic [11:0] adr;       // byte offset in the i/o page, word aligned
        logic [31:0] wdata;
        logic [3:0]  be;
        logic        rnw;
        logic        ena;       // single cycle strobe
    } io_bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        done;
    } io_bus_rsp_t;

    typedef enum logic [1:0] {
        blk_none,
        blk_timer,
        blk_keypad,
        blk_irq
    } io_block_e;

    // write as seen by a block, word index relative to the block
    typedef struct packed {
        logic [5:0]  word;
        logic [31:0] wdata;
        logic [3:0]  be;
    } io_wr_t;

    ////////////////////
    // register map

    localparam logic [11:0] adr_tm_base  = 12'h100;  // 4 bytes per timer
    localparam logic [11:0] adr_keyinput = 12'h130;
    localparam logic [11:0] adr_ie       = 12'h200;
    localparam logic [11:0] adr_ime      = 12'h208;
    localparam logic [11:0] adr_haltcnt  = 12'h300;

    localparam int max_timers = 4;

    // word indices inside the irq block
    localparam logic [5:0] wd_ie   = 6'd0;
    localparam logic [5:0] wd_ime  = 6'((adr_ime - adr_ie) >> 2);
    localparam logic [5:0] wd_halt = 6'h3f;   // haltcnt lives outside the ie window

    ////////////////////
    // timers

    typedef enum logic [1:0] {
        presc_1,
        presc_64,
        presc_256,
        presc_1024
    } presc_e;

    typedef struct packed {
        presc_e prescale;
        logic   cascade;
        logic   irq_en;
        logic   start;
    } timer_ctrl_t;

    // bit positions in the control half-word
    localparam int tm_bit_cascade = 2;
    localparam int tm_bit_irq_en  = 6;
    localparam int tm_bit_start   = 7;

    ////////////////////
    // keypad

    typedef struct packed {
        logic l, r, down, up, left, right, start, select, b, a;  // a is bit 0
    } keypad_keys_t;

    localparam int key_bit_irq_en = 14;
    localparam int key_bit_and    = 15;

    ////////////////////
    // interrupts

    typedef struct packed {
        logic       rsvd13;
        logic       keypad;     // bit 12
        logic [4:0] rsvd;       // serial and dma sources, not present
        logic [3:0] timer;      // bits 3..6
        logic       lcdstat;
        logic       hblank;
        logic       vblank;     // bit 0
    } irq_src_t;

    localparam logic [13:0] irq_valid_mask = 14'h107f;

endpackage

//--- hw/io_bus_router.sv
// i/o bus router
// decodes the peripheral bus address into a block select and word index,
// strobes the block write enables, returns read data with a 1-cycle done

`timescale 1ns/1ps

module io_bus_router import gba_io_pkg::*; (
    input  logic        clk16,
    input  logic        resetn,
    input  io_bus_req_t bus_req,
    output io_bus_rsp_t bus_rsp,
    output logic        tm_wr_en,
    output logic        key_wr_en,
    output logic        irq_wr_en,
    output io_wr_t      blk_wr,
    input  logic [31:0] tm_rdata,
    input  logic [31:0] key_rdata,
    input  logic [31:0] irq_rdata
);

    io_block_e   sel;
    logic [5:0]  word;
    logic [31:0] rd_mux;
    logic        wr_stb;

    ////////////////////
    // address decode

    always_comb begin
        sel  = blk_none;
        word = '0;
        if (bus_req.adr[11:4] == adr_tm_base[11:4]) begin
            sel  = blk_timer;
            word = {4'b0000, bus_req.adr[3:2]};         // timer slot
        end else if (bus_req.adr[11:2] == adr_keyinput[11:2]) begin
            sel = blk_keypad;
        end else if (bus_req.adr[11:2] == adr_ie[11:2] ||
                     bus_req.adr[11:2] == adr_ime[11:2]) begin
            sel  = blk_irq;
            word = 6'((bus_req.adr - adr_ie) >> 2);
        end else if (bus_req.adr[11:2] == adr_haltcnt[11:2]) begin
            sel  = blk_irq;
            word = wd_halt;
        end
    end

    assign wr_stb    = bus_req.ena & ~bus_req.rnw;
    assign tm_wr_en  = wr_stb && sel == blk_timer;
    assign key_wr_en = wr_stb && sel == blk_keypad;
    assign irq_wr_en = wr_stb && sel == blk_irq;

    assign blk_wr.word  = word;          // shared by all blocks, also the read index
    assign blk_wr.wdata = bus_req.wdata;
    assign blk_wr.be    = bus_req.be;

    ////////////////////
    // read path

    always_comb begin
        case (sel)
            blk_timer:  rd_mux = tm_rdata;
            blk_keypad: rd_mux = key_rdata;
            blk_irq:    rd_mux = irq_rdata;
            default:    rd_mux = '0;     // unmapped
        endcase
    end

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            bus_rsp <= '0;
        end else begin
            bus_rsp.done  <= bus_req.ena;
            bus_rsp.rdata <= (bus_req.ena && bus_req.rnw) ? rd_mux : '0;
        end
    end

endmodule

//--- hw/timer_regs.sv
// timer registers
// reload and control registers for each timer slot, start edge detect
// for the counter load, and the count/control read word

`timescale 1ns/1ps

module timer_regs import gba_io_pkg::*; #(
    parameter int timer_count = 4
) (
    input  logic                         clk16,
    input  logic                         resetn,
    input  logic                         wr_en,
    input  io_wr_t                       wr,
    input  logic [max_timers-1:0][15:0]  tm_count,
    output timer_ctrl_t [max_timers-1:0] tm_ctrl,
    output logic [max_timers-1:0][15:0]  tm_reload,
    output logic [max_timers-1:0]        tm_load,
    output logic [31:0]                  rdata
);

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            tm_ctrl   <= '0;
            tm_reload <= '0;
            tm_load   <= '0;
        end else begin
            tm_load <= '0;
            for (int i = 0; i < max_timers; i++) begin
                if (wr_en && wr.word == 6'(i) && i < timer_count) begin
                    if (wr.be[0])
                        tm_reload[i][7:0] <= wr.wdata[7:0];
                    if (wr.be[1])
                        tm_reload[i][15:8] <= wr.wdata[15:8];
                    if (wr.be[2]) begin     // control low byte holds every field
                        tm_ctrl[i].prescale <= presc_e'(wr.wdata[17:16]);
                        tm_ctrl[i].cascade  <= wr.wdata[16 + tm_bit_cascade];
                        tm_ctrl[i].irq_en   <= wr.wdata[16 + tm_bit_irq_en];
                        tm_ctrl[i].start    <= wr.wdata[16 + tm_bit_start];
                        // start 0 -> 1 reloads the counter on the next edge
                        tm_load[i] <= ~tm_ctrl[i].start & wr.wdata[16 + tm_bit_start];
                    end
                end
            end
        end
    end

    ////////////////////
    // read: live count low, control high

    always_comb begin
        rdata = '0;
        for (int i = 0; i < max_timers; i++) begin
            if (wr.word == 6'(i) && i < timer_count) begin
                rdata = {8'h00,
                         tm_ctrl[i].start,
                         tm_ctrl[i].irq_en,
                         3'b000,
                         tm_ctrl[i].cascade,
                         tm_ctrl[i].prescale,
                         tm_count[i]};
            end
        end
    end

endmodule

//--- hw/timer_counters.sv
// timer counters
// per-slot prescaler and 16-bit up counter with reload on overflow,
// cascade from the slot below, overflow irq pulses and tick outputs

`timescale 1ns/1ps

module timer_counters import gba_io_pkg::*; #(
    parameter int timer_count = 4
) (
    input  logic                         clk16,
    input  logic                         resetn,
    input  timer_ctrl_t [max_timers-1:0] tm_ctrl,
    input  logic [max_timers-1:0][15:0]  tm_reload,
    input  logic [max_timers-1:0]        tm_load,
    output logic [max_timers-1:0][15:0]  tm_count,
    output logic [max_timers-1:0]        tm_overflow,
    output logic [1:0]                   timer_tick
);

    logic [max_timers-1:0][9:0] presc_q;
    logic [max_timers-1:0]      inc;        // count enable this cycle
    logic [max_timers-1:0]      wrap;       // 0xffff -> reload this cycle

    // prescaler bits that must all be set for one count
    function automatic logic [9:0] presc_mask(input presc_e p);
        case (p)
            presc_64:   return 10'h03f;
            presc_256:  return 10'h0ff;
            presc_1024: return 10'h3ff;
            default:    return 10'h000;
        endcase
    endfunction

    ////////////////////
    // count enables, slot by slot so cascade sees the lower wrap

    always_comb begin : inc_chain
        logic carry;
        carry = 1'b0;
        for (int i = 0; i < max_timers; i++) begin
            if (i >= timer_count || !tm_ctrl[i].start)
                inc[i] = 1'b0;
            else if (i > 0 && tm_ctrl[i].cascade)
                inc[i] = carry;             // overflow of slot i-1
            else
                inc[i] = (presc_q[i] & presc_mask(tm_ctrl[i].prescale)) ==
                         presc_mask(tm_ctrl[i].prescale);
            wrap[i] = inc[i] && tm_count[i] == 16'hffff;
            carry   = wrap[i];
        end
    end

    ////////////////////
    // counters

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            presc_q     <= '0;
            tm_count    <= '0;
            tm_overflow <= '0;
            timer_tick  <= '0;
        end else begin
            for (int i = 0; i < max_timers; i++) begin
                if (tm_load[i]) begin
                    tm_count[i] <= tm_reload[i];
                    presc_q[i]  <= '0;      // full first period after start
                end else begin
                    if (tm_ctrl[i].start)
                        presc_q[i] <= presc_q[i] + 10'd1;
                    if (wrap[i])
                        tm_count[i] <= tm_reload[i];
                    else if (inc[i])
                        tm_count[i] <= tm_count[i] + 16'd1;
                end
                tm_overflow[i] <= wrap[i] & tm_ctrl[i].irq_en;
            end
            timer_tick <= wrap[1:0];        // timers 0 and 1 only
        end
    end

endmodule

//--- hw/keypad.sv
// keypad registers
// synchronised key status (active low) and key control with
// or/and interrupt condition

`timescale 1ns/1ps

module keypad import gba_io_pkg::*; (
    input  logic         clk16,
    input  logic         resetn,
    input  keypad_keys_t keys,
    input  logic         wr_en,
    input  io_wr_t       wr,
    output logic [31:0]  rdata,
    output logic         key_irq
);

    keypad_keys_t key_meta, key_sync;
    logic [9:0]   key_mask;
    logic         key_irq_en;
    logic         key_and;
    logic [9:0]   masked;
    logic         cond, cond_q;

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            key_meta   <= '0;
            key_sync   <= '0;
            key_mask   <= '0;
            key_irq_en <= 1'b0;
            key_and    <= 1'b0;
            cond_q     <= 1'b0;
        end else begin
            key_meta <= keys;
            key_sync <= key_meta;
            cond_q   <= cond;
            if (wr_en && wr.word == 6'd0) begin   // status half is read only
                if (wr.be[2])
                    key_mask[7:0] <= wr.wdata[23:16];
                if (wr.be[3]) begin
                    key_mask[9:8] <= wr.wdata[25:24];
                    key_irq_en    <= wr.wdata[16 + key_bit_irq_en];
                    key_and       <= wr.wdata[16 + key_bit_and];
                end
            end
        end
    end

    assign masked = key_sync & key_mask;
    assign cond   = key_and ? (masked == key_mask && key_mask != '0) : |masked;
    assign key_irq = cond & ~cond_q & key_irq_en;     // rising edge only

    assign rdata = (wr.word == 6'd0) ?
                   {key_and, key_irq_en, 4'b0000, key_mask, 6'b000000, ~key_sync} : '0;

endmodule

//--- hw/irq_controller.sv
// interrupt controller
// enable, request and master-enable registers, halt latch,
// level interrupt line to the cpu

`timescale 1ns/1ps

module irq_controller import gba_io_pkg::*; (
    input  logic        clk16,
    input  logic        resetn,
    input  logic        wr_en,
    input  io_wr_t      wr,
    output logic [31:0] rdata,
    input  irq_src_t    src,
    output logic        cpu_irq,
    output logic        halt
);

    logic [13:0] ie_q;
    logic [13:0] req_q;
    logic        ime_q;
    logic [13:0] req_clr;
    logic [13:0] pending;

    ////////////////////
    // write-one-to-clear on the request half

    always_comb begin
        req_clr = '0;
        if (wr_en && wr.word == wd_ie) begin
            if (wr.be[2])
                req_clr[7:0] = wr.wdata[23:16];
            if (wr.be[3])
                req_clr[13:8] = wr.wdata[29:24];
        end
    end

    assign pending = ie_q & req_q;
    assign cpu_irq = ime_q & |pending;

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            ie_q  <= '0;
            req_q <= '0;
            ime_q <= 1'b0;
            halt  <= 1'b0;
        end else begin
            // a new source pulse wins over a clear in the same cycle
            req_q <= ((req_q & ~req_clr) | src) & irq_valid_mask;

            if (wr_en && wr.word == wd_ie) begin
                if (wr.be[0])
                    ie_q[7:0] <= wr.wdata[7:0] & irq_valid_mask[7:0];
                if (wr.be[1])
                    ie_q[13:8] <= wr.wdata[13:8] & irq_valid_mask[13:8];
            end
            if (wr_en && wr.word == wd_ime && wr.be[0])
                ime_q <= wr.wdata[0];

            // wake up ignores ime
            if (|pending)
                halt <= 1'b0;
            else if (wr_en && wr.word == wd_halt && wr.be[1])
                halt <= 1'b1;
        end
    end

    ////////////////////
    // read path, haltcnt is write only

    always_comb begin
        case (wr.word)
            wd_ie:   rdata = {2'b00, req_q, 2'b00, ie_q};
            wd_ime:  rdata = {31'd0, ime_q};
            default: rdata = '0;
        endcase
    end

endmodule

//--- hw/gba_io_top.sv
// gba i/o subsystem top
// peripheral bus router with timers, keypad and interrupt controller

`timescale 1ns/1ps

module gba_io_top import gba_io_pkg::*; #(
    parameter int timer_count = 4
) (
    input  logic         clk16,
    input  logic         resetn,
    input  io_bus_req_t  bus_req,
    output io_bus_rsp_t  bus_rsp,
    input  keypad_keys_t keys,
    input  logic         vblank,
    input  logic         hblank,
    input  logic         lcdstat,
    output logic         cpu_irq,
    output logic         halt,
    output logic [1:0]   timer_tick
);

    logic                         tm_wr_en, key_wr_en, irq_wr_en;
    io_wr_t                       blk_wr;
    logic [31:0]                  tm_rdata, key_rdata, irq_rdata;
    timer_ctrl_t [max_timers-1:0] tm_ctrl;
    logic [max_timers-1:0][15:0]  tm_reload, tm_count;
    logic [max_timers-1:0]        tm_load, tm_overflow;
    logic                         key_irq;
    irq_src_t                     irq_src;

    assign irq_src = '{rsvd13: 1'b0, keypad: key_irq, rsvd: 5'b00000, timer: tm_overflow,
                       lcdstat: lcdstat, hblank: hblank, vblank: vblank};

    io_bus_router io_bus_router_inst (
        .clk16(clk16), .resetn(resetn), .bus_req(bus_req), .bus_rsp(bus_rsp),
        .tm_wr_en(tm_wr_en), .key_wr_en(key_wr_en), .irq_wr_en(irq_wr_en), .blk_wr(blk_wr),
        .tm_rdata(tm_rdata), .key_rdata(key_rdata), .irq_rdata(irq_rdata)
    );

    timer_regs #(.timer_count(timer_count)) timer_regs_inst (
        .clk16(clk16), .resetn(resetn), .wr_en(tm_wr_en), .wr(blk_wr), .tm_count(tm_count),
        .tm_ctrl(tm_ctrl), .tm_reload(tm_reload), .tm_load(tm_load), .rdata(tm_rdata)
    );

    timer_counters #(.timer_count(timer_count)) timer_counters_inst (
        .clk16(clk16), .resetn(resetn), .tm_ctrl(tm_ctrl), .tm_reload(tm_reload),
        .tm_load(tm_load), .tm_count(tm_count), .tm_overflow(tm_overflow),
        .timer_tick(timer_tick)
    );

    keypad keypad_inst (
        .clk16(clk16), .resetn(resetn), .keys(keys), .wr_en(key_wr_en), .wr(blk_wr),
        .rdata(key_rdata), .key_irq(key_irq)
    );

    irq_controller irq_controller_inst (
        .clk16(clk16), .resetn(resetn), .wr_en(irq_wr_en), .wr(blk_wr), .rdata(irq_rdata),
        .src(irq_src), .cpu_irq(cpu_irq), .halt(halt)
    );

endmodule

//--- bench/tb_checks.svh
// testbench helpers for the gba i/o subsystem
// bus access, bounded waits and typed compare tasks

`ifndef tb_checks_svh
`define tb_checks_svh

// one clock, ending at the drive point after the edge
task automatic step();
    @(posedge clk16);
    #2;
endtask

task automatic bus_write(input logic [11:0] adr, input logic [31:0] data,
                         input logic [3:0] be);
    bus_req = '{adr: adr, wdata: data, be: be, rnw: 1'b0, ena: 1'b1};
    step();
    bus_req.ena = 1'b0;
    if (bus_rsp.done !== 1'b1) begin
        $display("write to 0x%03h got no done one cycle after the request", adr);
        error_count++;
    end
endtask

task automatic bus_read(input logic [11:0] adr, output io_bus_rsp_t rsp);
    bus_req = '{adr: adr, wdata: 32'd0, be: 4'hf, rnw: 1'b1, ena: 1'b1};
    step();
    bus_req.ena = 1'b0;
    rsp = bus_rsp;                  // rdata valid while done is high
    if (rsp.done !== 1'b1) begin
        $display("read of 0x%03h got no done one cycle after the request", adr);
        error_count++;
    end
endtask

////////////////////
// compares

task automatic check_word(input string name, input logic [31:0] exp, input io_bus_rsp_t rsp);
    if (rsp.rdata !== exp) begin
        $display("[FAIL] %0t ns %s: expected 0x%08h, got 0x%08h", $time, name, exp, rsp.rdata);
        error_count++;
    end
endtask

task automatic check_keys(input string name, input keypad_keys_t exp, input keypad_keys_t act);
    if (act !== exp) begin
        $display("[FAIL] %0t ns %s: expected 0x%03h, got 0x%03h", $time, name, exp, act);
        error_count++;
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("[FAIL] %0t ns %s: expected %b, got %b", $time, name, exp, act);
        error_count++;
    end
endtask

task automatic check_gap(input string name, input int exp, input int act);
    if (act != exp) begin
        $display("[FAIL] %0t ns %s: expected %0d cycles, got %0d", $time, name, exp, act);
        error_count++;
    end
endtask

////////////////////
// bounded waits

task automatic wait_req_bit(input int bit_idx, input int limit);
    io_bus_rsp_t rsp;
    int          n;
    for (n = 0; n < limit; n++) begin
        bus_read(adr_ie, rsp);
        if (rsp.rdata[16 + bit_idx])
            break;
    end
    if (n == limit) begin
        $display("timed out after %0d reads waiting for request bit %0d", limit, bit_idx);
        timeout_count++;
    end
endtask

// cycles from the call until the next tick on timer_tick[idx]
task automatic wait_tick(input int idx, input int limit, output int cycles);
    for (cycles = 1; cycles <= limit; cycles++) begin
        step();
        if (timer_tick[idx])
            break;
    end
    if (cycles > limit) begin
        $display("timed out after %0d cycles waiting for a tick of timer %0d", limit, idx);
        timeout_count++;
    end
endtask

task automatic wait_halt_clear(input int limit);
    int n;
    for (n = 0; n < limit && halt; n++)
        step();
    if (halt) begin
        $display("timed out after %0d cycles waiting for halt to release", limit);
        timeout_count++;
    end
endtask

`endif

//--- bench/tb_gba_io.sv
// directed testbench for the gba i/o subsystem
// register access, keypad, timers, interrupt controller and halt

`timescale 1ns/1ps

module tb_gba_io import gba_io_pkg::*; ();

    logic         clk16;
    logic         resetn;
    io_bus_req_t  bus_req;
    io_bus_rsp_t  bus_rsp;
    keypad_keys_t keys;
    logic         vblank, hblank, lcdstat;
    logic         cpu_irq, halt;
    logic [1:0]   timer_tick;
    int           error_count;
    int           timeout_count;
    int           seed;

    `include "tb_checks.svh"

    gba_io_top #(.timer_count(4)) gba_io_top_inst (
        .clk16(clk16), .resetn(resetn), .bus_req(bus_req), .bus_rsp(bus_rsp), .keys(keys),
        .vblank(vblank), .hblank(hblank), .lcdstat(lcdstat),
        .cpu_irq(cpu_irq), .halt(halt), .timer_tick(timer_tick)
    );

    initial begin
        clk16 = 1'b0;
        forever #10 clk16 = ~clk16;     // 50 MHz
    end

    ////////////////////
    // directed tests

    task automatic check_reset_state();
        io_bus_rsp_t rsp;
        bus_read(adr_ie, rsp);
        check_word("ie/if", 32'd0, rsp);
        bus_read(adr_ime, rsp);
        check_word("ime", 32'd0, rsp);
        for (int i = 0; i < max_timers; i++) begin
            bus_read(adr_tm_base + 12'(4 * i), rsp);
            check_word("timer word", 32'd0, rsp);
        end
        bus_read(adr_keyinput, rsp);
        check_word("keyinput", 32'h0000_03ff, rsp);   // all released
        bus_read(12'h050, rsp);
        check_word("unmapped 0x050", 32'd0, rsp);
        check_bit("cpu_irq", 1'b0, cpu_irq);
        check_bit("halt", 1'b0, halt);
    endtask

    task automatic run_keypad();
        io_bus_rsp_t  rsp;
        keypad_keys_t pattern;
        logic [31:0]  r;
        for (int n = 0; n < 10; n++) begin
            r       = $random(seed);
            pattern = r[9:0];
            keys    = pattern;
            repeat (3) step();                        // through the synchroniser
            bus_read(adr_keyinput, rsp);
            check_keys("key status", ~pattern, rsp.rdata[9:0]);
        end
        keys = '0;
        repeat (3) step();
        bus_write(adr_ie, 32'h1000_0000, 4'b1100);    // clear request bit 12
        bus_write(adr_keyinput, 32'h4003_0000, 4'b1100);  // or mode, a|b
        keys.b = 1'b1;
        wait_req_bit(12, 20);
        keys = '0;
        repeat (3) step();
        bus_write(adr_ie, 32'h1000_0000, 4'b1100);
        bus_write(adr_keyinput, 32'hc003_0000, 4'b1100);  // and mode, a&b
        keys.a = 1'b1;
        repeat (8) step();
        bus_read(adr_ie, rsp);
        check_bit("keypad request, one of two keys", 1'b0, rsp.rdata[28]);
        keys.b = 1'b1;
        wait_req_bit(12, 20);
        keys = '0;
        bus_write(adr_keyinput, 32'd0, 4'b1100);
    endtask

    task automatic run_timer_overflow();
        io_bus_rsp_t rsp;
        int          gap;
        bus_write(adr_ie, 32'h0008_0000, 4'b0100);
        bus_write(adr_tm_base, 32'h00c0_fff0, 4'b0111);   // start, irq_en, presc_1
        wait_req_bit(3, 40);
        wait_tick(0, 40, gap);
        wait_tick(0, 40, gap);
        check_gap("timer 0 tick spacing", 16, gap);
        bus_read(adr_tm_base, rsp);
        check_bit("timer 0 count in reload range", 1'b1, rsp.rdata[15:0] >= 16'hfff0);
    endtask

    task automatic run_prescale_cascade();
        int gap;
        bus_write(adr_tm_base, 32'h0000_ffff, 4'b0111);           // stop timer 0
        bus_write(adr_tm_base + 12'h004, 32'h0084_fffe, 4'b0111); // timer 1 cascaded
        bus_write(adr_tm_base, 32'h0081_ffff, 4'b0111);           // presc_64
        wait_tick(0, 200, gap);
        wait_tick(0, 200, gap);
        check_gap("timer 0 tick spacing at presc_64", 64, gap);
        wait_tick(1, 400, gap);
        wait_tick(1, 400, gap);
        check_gap("timer 1 cascade tick spacing", 128, gap);
        bus_write(adr_tm_base, 32'd0, 4'b0100);
        bus_write(adr_tm_base + 12'h004, 32'd0, 4'b0100);
    endtask

    task automatic run_irq_halt();
        io_bus_rsp_t rsp;
        bus_write(adr_ie, 32'h3fff_0000, 4'b1100);    // drop stale requests
        bus_write(adr_ie, 32'h0000_0001, 4'b0011);    // vblank enabled, ime still clear
        vblank = 1'b1;
        step();
        vblank = 1'b0;
        wait_req_bit(0, 10);
        check_bit("cpu_irq with ime clear", 1'b0, cpu_irq);
        bus_write(adr_ime, 32'h0000_0001, 4'b0001);
        check_bit("cpu_irq after ie and ime", 1'b1, cpu_irq);
        bus_write(adr_ie, 32'h0001_0000, 4'b0100);
        check_bit("cpu_irq after request clear", 1'b0, cpu_irq);
        bus_read(adr_ie, rsp);
        check_word("ie/if after clear", 32'h0000_0001, rsp);
        bus_write(adr_ie, 32'h0000_0003, 4'b0011);    // vblank and hblank
        bus_write(adr_haltcnt, 32'd0, 4'b0010);
        check_bit("halt after haltcnt write", 1'b1, halt);
        hblank = 1'b1;
        step();
        hblank = 1'b0;
        wait_halt_clear(10);
        check_bit("cpu_irq after hblank", 1'b1, cpu_irq);
    endtask

    ////////////////////
    // sequence

    initial begin
        error_count   = 0;
        timeout_count = 0;
        seed          = 94;
        resetn        = 1'b0;
        bus_req       = '0;
        keys          = '0;
        vblank        = 1'b0;
        hblank        = 1'b0;
        lcdstat       = 1'b0;
        repeat (16) step();
        resetn = 1'b1;
        step();
        check_reset_state();
        run_keypad();
        run_timer_overflow();
        run_prescale_cascade();
        run_irq_halt();
        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- project.f
+incdir+bench
hw/gba_io_pkg.sv
hw/io_bus_router.sv
hw/timer_regs.sv
hw/timer_counters.sv
hw/keypad.sv
hw/irq_controller.sv
hw/gba_io_top.sv
bench/tb_gba_io.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -sv -f project.f --top-module tb_gba_io \
    -Mdir obj_dir -o sim_gba_io
./obj_dir/sim_gba_io | tee sim.log

if grep -q "Done: no errors" sim.log; then
    exit 0
else
    exit 1
fi
